// ==== common/stage2_pkg.sv ====
package stage2_pkg;

    // ========================================
    // datapath widths
    // ========================================
    localparam int PIX_W  = 8;   // unsigned input pixel
    localparam int WGT_W  = 8;   // signed kernel weight
    localparam int BIAS_W = 16;  // signed bias
    localparam int ACC_W  = 21;  // signed sum of nine products plus bias
    localparam int FMAP_W = 19;  // feature point after relu

    // apb bus
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // ========================================
    // register map
    // ========================================
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;  // bit 0 enable
    localparam logic [APB_AW-1:0] ADDR_WGT0   = 8'h04;  // weights 0..3
    localparam logic [APB_AW-1:0] ADDR_WGT1   = 8'h08;  // weights 4..7
    localparam logic [APB_AW-1:0] ADDR_WGT2   = 8'h0C;  // weight 8, low byte
    localparam logic [APB_AW-1:0] ADDR_BIAS   = 8'h10;  // low 16 bits
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h14;  // pooled point count, ro

    // ========================================
    // configuration write word
    // ========================================
    typedef logic signed [WGT_W-1:0] wgt_byte_t;

    // bias register layout
    typedef struct packed {
        logic [APB_DW-BIAS_W-1:0] pad;
        logic signed [BIAS_W-1:0] bias;
    } bias_word_t;

    // one apb data word, seen either as four weight bytes or as the bias field
    // byte 0 of the weight view is the lowest-numbered weight of that register
    typedef union packed {
        wgt_byte_t [3:0] wgt;
        bias_word_t      bias_f;
    } cfg_word_u;

endpackage

// ==== hw/stage2_cfg_apb.sv ====
`timescale 1ns/1ns

module stage2_cfg_apb (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [stage2_pkg::APB_AW-1:0]       i_paddr,
    input  logic [stage2_pkg::APB_DW-1:0]       i_pwdata,
    input  logic                                i_pool_valid,
    output logic [stage2_pkg::APB_DW-1:0]       o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,
    output logic                                o_enable,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt0,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt1,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt2,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt3,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt4,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt5,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt6,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt7,
    output logic signed [stage2_pkg::WGT_W-1:0] o_wgt8,
    output logic signed [stage2_pkg::BIAS_W-1:0] o_bias
);

    logic                              access;
    logic                              addr_hit;
    logic                              wr_en;
    logic                              enable_rise;
    stage2_pkg::cfg_word_u             wr_word;
    logic [stage2_pkg::WGT_W-1:0]      wgt_q [0:8];
    logic [stage2_pkg::BIAS_W-1:0]     bias_q;
    logic                              enable_q;
    logic [stage2_pkg::APB_DW-1:0]     status_q;

    assign access  = i_psel & i_penable;
    assign wr_word = i_pwdata;
    assign wr_en   = access & i_pwrite & addr_hit;

    // 0 -> 1 on enable restarts the point count
    assign enable_rise = wr_en && (i_paddr == stage2_pkg::ADDR_CTRL) && i_pwdata[0] && !enable_q;

    always_comb begin
        case (i_paddr)
            stage2_pkg::ADDR_CTRL,
            stage2_pkg::ADDR_WGT0,
            stage2_pkg::ADDR_WGT1,
            stage2_pkg::ADDR_WGT2,
            stage2_pkg::ADDR_BIAS,
            stage2_pkg::ADDR_STATUS: addr_hit = 1'b1;
            default:                 addr_hit = 1'b0;
        endcase
    end

    assign o_pready  = 1'b1;          // no wait states
    assign o_pslverr = access & ~addr_hit;

    // ========================================
    // config registers
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_q <= 1'b0;
            bias_q   <= '0;
            for (int k = 0; k < 9; k++) begin
                wgt_q[k] <= '0;
            end
        end else if (wr_en) begin
            case (i_paddr)
                stage2_pkg::ADDR_CTRL: enable_q <= i_pwdata[0];
                stage2_pkg::ADDR_WGT0: begin
                    for (int k = 0; k < 4; k++) begin
                        wgt_q[k] <= wr_word.wgt[k];
                    end
                end
                stage2_pkg::ADDR_WGT1: begin
                    for (int k = 0; k < 4; k++) begin
                        wgt_q[k+4] <= wr_word.wgt[k];
                    end
                end
                stage2_pkg::ADDR_WGT2: wgt_q[8] <= wr_word.wgt[0];
                stage2_pkg::ADDR_BIAS: bias_q   <= wr_word.bias_f.bias;
                default: ;                    // status is read only
            endcase
        end
    end

    // pooled point counter
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            status_q <= '0;
        end else if (enable_rise) begin
            status_q <= '0;
        end else if (i_pool_valid) begin
            status_q <= status_q + 1'b1;
        end
    end

    // read mux, unmapped offsets read zero
    always_comb begin
        o_prdata = '0;
        if (access && !i_pwrite) begin
            case (i_paddr)
                stage2_pkg::ADDR_CTRL:   o_prdata = {{(stage2_pkg::APB_DW-1){1'b0}}, enable_q};
                stage2_pkg::ADDR_WGT0:   o_prdata = {wgt_q[3], wgt_q[2], wgt_q[1], wgt_q[0]};
                stage2_pkg::ADDR_WGT1:   o_prdata = {wgt_q[7], wgt_q[6], wgt_q[5], wgt_q[4]};
                stage2_pkg::ADDR_WGT2:   o_prdata = {{(stage2_pkg::APB_DW-stage2_pkg::WGT_W){1'b0}},
                                                     wgt_q[8]};
                stage2_pkg::ADDR_BIAS:   o_prdata = {{(stage2_pkg::APB_DW-stage2_pkg::BIAS_W){1'b0}},
                                                     bias_q};
                stage2_pkg::ADDR_STATUS: o_prdata = status_q;
                default:                 o_prdata = '0;
            endcase
        end
    end

    assign o_enable = enable_q;
    assign o_wgt0   = wgt_q[0];
    assign o_wgt1   = wgt_q[1];
    assign o_wgt2   = wgt_q[2];
    assign o_wgt3   = wgt_q[3];
    assign o_wgt4   = wgt_q[4];
    assign o_wgt5   = wgt_q[5];
    assign o_wgt6   = wgt_q[6];
    assign o_wgt7   = wgt_q[7];
    assign o_wgt8   = wgt_q[8];
    assign o_bias   = bias_q;

endmodule

// ==== conv/stage2_conv3x3.sv ====
`timescale 1ns/1ns

module stage2_conv3x3 #(
    parameter int IMG_W = 26,
    parameter int IMG_H = 26
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 i_enable,
    input  logic                                 i_in_valid,
    input  logic [stage2_pkg::PIX_W-1:0]         i_in_pix,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt0,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt1,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt2,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt3,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt4,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt5,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt6,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt7,
    input  logic signed [stage2_pkg::WGT_W-1:0]  i_wgt8,
    input  logic signed [stage2_pkg::BIAS_W-1:0] i_bias,
    output logic                                 o_conv_valid,
    output logic [stage2_pkg::FMAP_W-1:0]        o_conv_fmap
);

    localparam int ROW_W  = $clog2(IMG_H);
    localparam int COL_W  = $clog2(IMG_W);
    localparam int PROD_W = stage2_pkg::PIX_W + 1 + stage2_pkg::WGT_W;  // 17

    logic [ROW_W-1:0]                    row;
    logic [COL_W-1:0]                    col;
    logic                                accept;
    logic [stage2_pkg::PIX_W-1:0]        line_buf0 [0:IMG_W-1];  // row r-2
    logic [stage2_pkg::PIX_W-1:0]        line_buf1 [0:IMG_W-1];  // row r-1
    logic [stage2_pkg::PIX_W-1:0]        win [0:2][0:2];         // [row][col], 0 is oldest
    logic                                win_vld;
    logic                                prod_vld;
    logic signed [stage2_pkg::WGT_W-1:0] wgt [0:8];
    logic signed [PROD_W-1:0]            prod [0:8];
    logic signed [stage2_pkg::ACC_W-1:0] sum;

    assign accept = i_enable & i_in_valid;

    assign wgt[0] = i_wgt0;
    assign wgt[1] = i_wgt1;
    assign wgt[2] = i_wgt2;
    assign wgt[3] = i_wgt3;
    assign wgt[4] = i_wgt4;
    assign wgt[5] = i_wgt5;
    assign wgt[6] = i_wgt6;
    assign wgt[7] = i_wgt7;
    assign wgt[8] = i_wgt8;

    // ========================================
    // row / col counters
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row <= '0;
            col <= '0;
        end else if (!i_enable) begin
            row <= '0;   // parked while disabled
            col <= '0;
        end else if (i_in_valid) begin
            if (col == COL_W'(IMG_W-1)) begin
                col <= '0;
                if (row == ROW_W'(IMG_H-1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ========================================
    // line buffers and 3x3 window
    // ========================================
    always_ff @(posedge clk) begin
        if (accept) begin
            line_buf0[col] <= line_buf1[col];
            line_buf1[col] <= i_in_pix;
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            // new column, top to bottom
            win[0][2] <= line_buf0[col];
            win[1][2] <= line_buf1[col];
            win[2][2] <= i_in_pix;
        end
    end

    // window is complete once two rows and two columns are behind us
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_vld      <= 1'b0;
            prod_vld     <= 1'b0;
            o_conv_valid <= 1'b0;
        end else begin
            win_vld      <= accept && (row >= ROW_W'(2)) && (col >= COL_W'(2));
            prod_vld     <= win_vld;
            o_conv_valid <= prod_vld;
        end
    end

    // stage 1, nine products
    always_ff @(posedge clk) begin
        if (win_vld) begin
            for (int k = 0; k < 9; k++) begin
                prod[k] <= $signed({1'b0, win[k/3][k%3]}) * wgt[k];
            end
        end
    end

    // adder tree plus bias
    always_comb begin
        sum = i_bias;
        for (int k = 0; k < 9; k++) begin
            sum = sum + prod[k];
        end
    end

    // stage 2, relu
    always_ff @(posedge clk) begin
        if (prod_vld) begin
            o_conv_fmap <= sum[stage2_pkg::ACC_W-1] ? '0 : sum[stage2_pkg::FMAP_W-1:0];
        end
    end

endmodule

// ==== pool/stage2_pooling.sv ====
`timescale 1ns/1ns

module stage2_pooling #(
    parameter int IMG_W = 26,
    parameter int IMG_H = 26
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_in_valid,
    input  logic [stage2_pkg::FMAP_W-1:0] i_in_fmap,
    output logic                          o_ot_valid,
    output logic [stage2_pkg::FMAP_W-1:0] o_ot_fmap
);

    // feature map shrinks by the 3x3 kernel border
    localparam int FM_W  = IMG_W - 2;
    localparam int FM_H  = IMG_H - 2;
    localparam int ROW_W = $clog2(FM_H);
    localparam int COL_W = $clog2(FM_W);

    logic [ROW_W-1:0]              row;
    logic [COL_W-1:0]              col;
    logic [COL_W-1:0]              col_even;
    logic                          pool_hit;
    logic [stage2_pkg::FMAP_W-1:0] line_buf [0:FM_W-1];  // previous feature row
    logic [stage2_pkg::FMAP_W-1:0] prev_pt;              // left neighbour, current row
    logic [stage2_pkg::FMAP_W-1:0] max_top;
    logic [stage2_pkg::FMAP_W-1:0] max_bot;
    logic [stage2_pkg::FMAP_W-1:0] pool_max;

    function automatic logic [stage2_pkg::FMAP_W-1:0] max2(
        input logic [stage2_pkg::FMAP_W-1:0] a,
        input logic [stage2_pkg::FMAP_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    // ========================================
    // row / col counters
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row <= '0;
            col <= '0;
        end else if (i_in_valid) begin
            if (col == COL_W'(FM_W-1)) begin
                col <= '0;
                if (row == ROW_W'(FM_H-1)) begin
                    row <= '0;      // frame done
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // bottom-right corner of a 2x2 block
    assign pool_hit = i_in_valid & row[0] & col[0];
    assign col_even = {col[COL_W-1:1], 1'b0};

    // ========================================
    // point storage
    // ========================================
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            if (!row[0]) begin
                line_buf[col] <= i_in_fmap;  // even rows only, read back on the odd row
            end
            prev_pt <= i_in_fmap;
        end
    end

    // comparison tree over the 2x2 block
    assign max_top  = max2(line_buf[col_even], line_buf[col]);
    assign max_bot  = max2(prev_pt, i_in_fmap);
    assign pool_max = max2(max_top, max_bot);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_ot_valid <= 1'b0;
        end else begin
            o_ot_valid <= pool_hit;  // single-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (pool_hit) begin
            o_ot_fmap <= pool_max;
        end
    end

endmodule

// ==== hw/stage2_core_top.sv ====
`timescale 1ns/1ns

module stage2_core_top #(
    parameter int IMG_W = 26,
    parameter int IMG_H = 26
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [stage2_pkg::APB_AW-1:0] i_paddr,
    input  logic [stage2_pkg::APB_DW-1:0] i_pwdata,
    output logic [stage2_pkg::APB_DW-1:0] o_prdata,
    output logic                          o_pready,
    output logic                          o_pslverr,
    input  logic                          i_in_valid,
    input  logic [stage2_pkg::PIX_W-1:0]  i_in_pix,
    output logic                          o_ot_valid,
    output logic [stage2_pkg::FMAP_W-1:0] o_ot_fmap
);

    logic                                 enable;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt0;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt1;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt2;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt3;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt4;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt5;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt6;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt7;
    logic signed [stage2_pkg::WGT_W-1:0]  wgt8;
    logic signed [stage2_pkg::BIAS_W-1:0] bias;
    logic                                 conv_valid;
    logic [stage2_pkg::FMAP_W-1:0]        conv_fmap;

    // ========================================
    // register block
    // ========================================
    stage2_cfg_apb u_cfg (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .i_pool_valid (o_ot_valid),   // counts pooled points
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_enable     (enable),
        .o_wgt0       (wgt0),
        .o_wgt1       (wgt1),
        .o_wgt2       (wgt2),
        .o_wgt3       (wgt3),
        .o_wgt4       (wgt4),
        .o_wgt5       (wgt5),
        .o_wgt6       (wgt6),
        .o_wgt7       (wgt7),
        .o_wgt8       (wgt8),
        .o_bias       (bias)
    );

    // ========================================
    // datapath
    // ========================================
    stage2_conv3x3 #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_conv (
        .clk          (clk),
        .reset_n      (reset_n),
        .i_enable     (enable),
        .i_in_valid   (i_in_valid),
        .i_in_pix     (i_in_pix),
        .i_wgt0       (wgt0),
        .i_wgt1       (wgt1),
        .i_wgt2       (wgt2),
        .i_wgt3       (wgt3),
        .i_wgt4       (wgt4),
        .i_wgt5       (wgt5),
        .i_wgt6       (wgt6),
        .i_wgt7       (wgt7),
        .i_wgt8       (wgt8),
        .i_bias       (bias),
        .o_conv_valid (conv_valid),
        .o_conv_fmap  (conv_fmap)
    );

    stage2_pooling #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_pool (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (conv_valid),
        .i_in_fmap  (conv_fmap),
        .o_ot_valid (o_ot_valid),
        .o_ot_fmap  (o_ot_fmap)
    );

endmodule

// ==== dv/stage2_core_asserts.sv ====
`timescale 1ns/1ns

module stage2_core_asserts (
    input logic clk,
    input logic reset_n,
    input logic i_psel,
    input logic i_penable,
    input logic i_pready,
    input logic i_pslverr,
    input logic i_ot_valid
);

    int fail_count = 0;  // assertion failures so far

    // ========================================
    // apb
    // ========================================
    a_pready_high: assert property (@(posedge clk) disable iff (!reset_n) i_pready)
        else begin
            fail_count++;
            $error("pready went low");
        end

    a_pslverr_access: assert property (@(posedge clk) disable iff (!reset_n)
        i_pslverr |-> (i_psel && i_penable))
        else begin
            fail_count++;
            $error("pslverr outside an access cycle");
        end

    // pooled stream
    a_valid_known: assert property (@(posedge clk) disable iff (!reset_n) !$isunknown(i_ot_valid))
        else begin
            fail_count++;
            $error("o_ot_valid is unknown");
        end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        i_ot_valid |=> !i_ot_valid)
        else begin
            fail_count++;
            $error("o_ot_valid high two cycles in a row");
        end

endmodule

bind stage2_core_top stage2_core_asserts u_asserts (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pready   (o_pready),
    .i_pslverr  (o_pslverr),
    .i_ot_valid (o_ot_valid)
);

// ==== dv/stage2_tb.sv ====
`timescale 1ns/1ns

module stage2_tb;

    localparam int IMG_W       = 26;
    localparam int IMG_H       = 26;
    localparam int FM_W        = IMG_W - 2;
    localparam int FM_H        = IMG_H - 2;
    localparam int POOL_PTS    = (FM_W / 2) * (FM_H / 2);  // 144 per frame
    localparam int CLK_PERIOD  = 100;
    localparam int N_TESTS     = 5;
    localparam int WATCHDOG_NS = N_TESTS * IMG_W * IMG_H * 3 * CLK_PERIOD + 500_000;

    // pattern kinds
    localparam int PAT_RAMP  = 0;
    localparam int PAT_RAND  = 1;
    localparam int PAT_FULL  = 2;  // every pixel 255
    localparam int PAT_CHECK = 3;

    logic                          clk;
    logic                          reset_n;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [stage2_pkg::APB_AW-1:0] paddr;
    logic [stage2_pkg::APB_DW-1:0] pwdata;
    logic [stage2_pkg::APB_DW-1:0] prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          in_valid;
    logic [stage2_pkg::PIX_W-1:0]  in_pix;
    logic                          ot_valid;
    logic [stage2_pkg::FMAP_W-1:0] ot_fmap;

    // stimulus table, one row per frame
    string  tbl_name [0:N_TESTS-1];
    int     tbl_pat  [0:N_TESTS-1];
    int     tbl_wgt  [0:N_TESTS-1][0:8];
    int     tbl_bias [0:N_TESTS-1];
    int     n_loaded;

    int     pix [0:IMG_H-1][0:IMG_W-1];
    int     got_q [$];
    int     exp_q [$];
    int     errors;
    int     assert_fails;
    integer seed;
    logic [31:0] rd;
    logic        err;

    stage2_core_top #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) DUT (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .o_pready   (pready),
        .o_pslverr  (pslverr),
        .i_in_valid (in_valid),
        .i_in_pix   (in_pix),
        .o_ot_valid (ot_valid),
        .o_ot_fmap  (ot_fmap)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // pooled points, sampled mid-cycle
    always @(negedge clk) begin
        if (ot_valid === 1'b1) begin
            got_q.push_back(int'(ot_fmap));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ========================================
    // helpers
    // ========================================
    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: expected %0d (0x%0h), actual %0d (0x%0h)",
                 name, exp, exp, act, act);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic add_entry(input string name, input int pat,
                             input int w0, input int w1, input int w2,
                             input int w3, input int w4, input int w5,
                             input int w6, input int w7, input int w8,
                             input int bias);
        tbl_name[n_loaded] = name;
        tbl_pat[n_loaded]  = pat;
        tbl_wgt[n_loaded][0] = w0;
        tbl_wgt[n_loaded][1] = w1;
        tbl_wgt[n_loaded][2] = w2;
        tbl_wgt[n_loaded][3] = w3;
        tbl_wgt[n_loaded][4] = w4;
        tbl_wgt[n_loaded][5] = w5;
        tbl_wgt[n_loaded][6] = w6;
        tbl_wgt[n_loaded][7] = w7;
        tbl_wgt[n_loaded][8] = w8;
        tbl_bias[n_loaded] = bias;
        n_loaded++;
    endtask

    // register word for up to four weights, lowest byte first
    function automatic logic [31:0] pack_weights(input int e, input int base);
        logic [31:0] word;
        word = '0;
        for (int b = 0; b < 4 && base + b < 9; b++) begin
            word[8*b +: 8] = 8'(tbl_wgt[e][base + b]);
        end
        return word;
    endfunction

    task automatic apb_write(input logic [stage2_pkg::APB_AW-1:0] addr,
                             input logic [31:0] data, output logic slv_err);
        @(negedge clk);
        psel    = 1'b1;  // setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;  // access
        #(CLK_PERIOD / 4);
        slv_err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [stage2_pkg::APB_AW-1:0] addr,
                            output logic [31:0] data, output logic slv_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);
        data    = prdata;
        slv_err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic fill_frame(input int pat);
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                case (pat)
                    PAT_RAMP: pix[r][c] = (r * IMG_W + c) % 256;
                    PAT_RAND: pix[r][c] = $random(seed) & 8'hFF;
                    PAT_FULL: pix[r][c] = 255;
                    default:  pix[r][c] = ((r + c) % 2) * 255;  // checkerboard
                endcase
            end
        end
    endtask

    // 3x3 conv, bias, relu, then 2x2 max over the feature map
    task automatic build_expected(input int e);
        int fmap [0:FM_H-1][0:FM_W-1];
        int acc;
        int best;
        exp_q.delete();
        for (int r = 0; r < FM_H; r++) begin
            for (int c = 0; c < FM_W; c++) begin
                acc = tbl_bias[e];
                for (int k = 0; k < 9; k++) begin
                    acc += tbl_wgt[e][k] * pix[r + k / 3][c + k % 3];
                end
                fmap[r][c] = (acc < 0) ? 0 : acc;
            end
        end
        for (int i = 0; i < FM_H / 2; i++) begin
            for (int j = 0; j < FM_W / 2; j++) begin
                best = fmap[2*i][2*j];
                if (fmap[2*i][2*j+1] > best) best = fmap[2*i][2*j+1];
                if (fmap[2*i+1][2*j] > best) best = fmap[2*i+1][2*j];
                if (fmap[2*i+1][2*j+1] > best) best = fmap[2*i+1][2*j+1];
                exp_q.push_back(best);
            end
        end
    endtask

    // one frame in raster order with random idle gaps
    task automatic stream_frame();
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                while (($random(seed) & 3) == 0) begin
                    in_valid = 1'b0;
                    @(negedge clk);
                end
                in_valid = 1'b1;
                in_pix   = 8'(pix[r][c]);
                @(negedge clk);
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic send_idle_beats(input int n);
        for (int i = 0; i < n; i++) begin
            in_valid = 1'b1;
            in_pix   = 8'($random(seed));
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_for_points(input int n);
        int waited;
        waited = 0;
        while (got_q.size() < n && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        repeat (4) @(negedge clk);  // let any stray pulse show up
    endtask

    // ========================================
    // one table entry
    // ========================================
    task automatic run_entry(input int e);
        logic [31:0] data;
        logic        slv_err;
        string       name;
        name = tbl_name[e];
        apb_write(stage2_pkg::ADDR_CTRL, 32'h0, slv_err);
        fill_frame(tbl_pat[e]);
        build_expected(e);
        apb_write(stage2_pkg::ADDR_WGT0, pack_weights(e, 0), slv_err);
        apb_write(stage2_pkg::ADDR_WGT1, pack_weights(e, 4), slv_err);
        apb_write(stage2_pkg::ADDR_WGT2, pack_weights(e, 8), slv_err);
        apb_write(stage2_pkg::ADDR_BIAS, 32'(tbl_bias[e]) & 32'h0000_FFFF, slv_err);

        // readback
        apb_read(stage2_pkg::ADDR_WGT0, data, slv_err);
        if (data !== pack_weights(e, 0)) report_mismatch({name, "/wgt0"}, pack_weights(e, 0), data);
        apb_read(stage2_pkg::ADDR_WGT1, data, slv_err);
        if (data !== pack_weights(e, 4)) report_mismatch({name, "/wgt1"}, pack_weights(e, 4), data);
        apb_read(stage2_pkg::ADDR_WGT2, data, slv_err);
        if (data !== pack_weights(e, 8)) report_mismatch({name, "/wgt2"}, pack_weights(e, 8), data);
        apb_read(stage2_pkg::ADDR_BIAS, data, slv_err);
        if (data !== (32'(tbl_bias[e]) & 32'h0000_FFFF)) begin
            report_mismatch({name, "/bias"}, 32'(tbl_bias[e]) & 32'h0000_FFFF, data);
        end
        if (slv_err !== 1'b0) report_failure({name, ": pslverr raised on a mapped read"});

        // beats while disabled must vanish
        got_q.delete();
        send_idle_beats(4 * IMG_W);  // deep enough to reach the first 2x2 block
        repeat (6) @(negedge clk);
        if (got_q.size() != 0) report_failure({name, ": pooled output seen while disabled"});

        apb_write(stage2_pkg::ADDR_CTRL, 32'h1, slv_err);
        apb_read(stage2_pkg::ADDR_STATUS, data, slv_err);
        if (data !== 32'd0) report_mismatch({name, "/status_clear"}, 32'd0, data);

        got_q.delete();
        stream_frame();
        wait_for_points(POOL_PTS);
        if (got_q.size() != POOL_PTS) begin
            report_mismatch({name, "/point_count"}, POOL_PTS, got_q.size());
        end else begin
            for (int k = 0; k < POOL_PTS; k++) begin
                if (got_q[k] != exp_q[k]) begin
                    report_mismatch($sformatf("%s[%0d]", name, k), exp_q[k], got_q[k]);
                end
            end
        end
        apb_read(stage2_pkg::ADDR_STATUS, data, slv_err);
        if (data !== 32'(POOL_PTS)) report_mismatch({name, "/status"}, POOL_PTS, data);
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        seed     = 32'h59ec_3052;
        errors   = 0;
        n_loaded = 0;
        reset_n  = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        in_valid = 1'b0;
        in_pix   = '0;

        //        name             pattern    w0    w1    w2    w3   w4    w5    w6   w7   w8  bias
        add_entry("ramp_mixed",    PAT_RAMP,   3,   -1,    2,   -4,   5,    1,   -2,   0,   7, -300);
        add_entry("random_sharp",  PAT_RAND,  12,   -7,    5,   -3,  20,   -9,    4,   6, -11, 1234);
        add_entry("relu_negative", PAT_FULL,  -1,   -2,   -3,   -4,  -5,   -6,   -7,  -8,  -9, -1000);
        add_entry("max_sum_full",  PAT_FULL, 127,  127,  127,  127, 127,  127,  127, 127, 127, 32767);
        add_entry("checker_max",   PAT_CHECK,  0,    0,    0,    0,   1,    0,    0,   0,   0, 0);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // unmapped offsets
        apb_read(8'h18, rd, err);
        if (err !== 1'b1) report_failure("read of unmapped offset 0x18 did not raise pslverr");
        if (rd !== 32'd0) report_mismatch("unmapped_read", 32'd0, rd);
        apb_write(8'h1C, 32'hFFFF_FFFF, err);
        if (err !== 1'b1) report_failure("write to unmapped offset 0x1C did not raise pslverr");

        for (int e = 0; e < N_TESTS; e++) begin
            run_entry(e);
        end

        repeat (5) @(negedge clk);
        assert_fails = DUT.u_asserts.fail_count;
        $display("check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
common/stage2_pkg.sv
hw/stage2_cfg_apb.sv
conv/stage2_conv3x3.sv
pool/stage2_pooling.sv
hw/stage2_core_top.sv
dv/stage2_core_asserts.sv
dv/stage2_tb.sv
